// File: Makefile
# Verilator lint and simulation of the AXI burst subsystem

VERILATOR ?= verilator
TOP       ?= axi_burst_subsystem_tb
FILELIST  ?= axi_burst_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: axi_burst_subsystem.f
+incdir+include
logic/axi_pkg.sv
logic/axi_burst_engine.sv
logic/axi_sram_slave.sv
logic/axi_protocol_checker.sv
logic/axi_burst_subsystem.sv
test/axi_burst_subsystem_tb.sv

// File: include/axi_defs.svh
/* Bus widths, SRAM depth, command length limit and burst page size
   for the AXI burst subsystem */

`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// Byte address and data widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32

// 8 KB of 32-bit words, two pages
`define SRAM_WORDS 2048

// Longest command in words
`define MAX_CMD_LEN 16

// No burst may cross this boundary
`define PAGE_BYTES 4096

`endif

// File: logic/axi_burst_engine.sv
/* AXI master burst engine that turns write and read commands
   into INCR bursts that never cross a page boundary */
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_burst_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_start,
    input  logic                          cmd_write,
    input  logic [`AXI_ADDR_WIDTH-1:0]    cmd_addr,
    input  logic [$clog2(`MAX_CMD_LEN):0] cmd_len,
    input  logic [`AXI_DATA_WIDTH-1:0]    cmd_pattern,
    output logic                          busy,
    output logic                          done,
    output logic                          error,
    output logic                          rd_valid,
    output logic [`AXI_DATA_WIDTH-1:0]    rd_data,
    output logic                          awvalid,
    input  logic                          awready,
    output logic [`AXI_ADDR_WIDTH-1:0]    awaddr,
    output logic [7:0]                    awlen,
    output logic [2:0]                    awsize,
    output axi_pkg::axi_burst_t           awburst,
    output logic                          wvalid,
    input  logic                          wready,
    output logic [`AXI_DATA_WIDTH-1:0]    wdata,
    output logic                          wlast,
    input  logic                          bvalid,
    output logic                          bready,
    input  axi_pkg::axi_resp_t            bresp,
    output logic                          arvalid,
    input  logic                          arready,
    output logic [`AXI_ADDR_WIDTH-1:0]    araddr,
    output logic [7:0]                    arlen,
    output logic [2:0]                    arsize,
    output axi_pkg::axi_burst_t           arburst,
    input  logic                          rvalid,
    output logic                          rready,
    input  logic [`AXI_DATA_WIDTH-1:0]    rdata,
    input  axi_pkg::axi_resp_t            rresp,
    input  logic                          rlast
);
    import axi_pkg::*;

    localparam int PAGE_BITS = $clog2(`PAGE_BYTES);
    localparam int LEN_BITS = $clog2(`MAX_CMD_LEN) + 1;

    typedef enum logic [2:0] {S_IDLE, S_ADDR, S_WDATA, S_WRESP, S_RDATA} state_t;

    state_t                     state;
    logic                       is_write;
    logic [`AXI_ADDR_WIDTH-1:0] addr;
    logic [LEN_BITS-1:0]        remaining;
    logic [LEN_BITS-1:0]        beat_idx;
    logic [LEN_BITS-1:0]        burst_left;
    logic [`AXI_DATA_WIDTH-1:0] pattern;
    logic                       err_acc;
    logic [PAGE_BITS:0]         words_to_page;
    logic [LEN_BITS-1:0]        burst_words;

    // Next burst stops at the page boundary or the end of the command
    assign words_to_page = (PAGE_BITS + 1)'(`PAGE_BYTES / 4)
        - (PAGE_BITS + 1)'(addr[PAGE_BITS-1:2]);
    assign burst_words = (words_to_page < (PAGE_BITS + 1)'(remaining))
        ? words_to_page[LEN_BITS-1:0] : remaining;

    assign busy = state != S_IDLE;

    assign awvalid = state == S_ADDR && is_write;
    assign arvalid = state == S_ADDR && !is_write;
    assign awaddr = addr;
    assign araddr = addr;
    assign awlen = 8'(burst_words) - 8'd1;
    assign arlen = 8'(burst_words) - 8'd1;
    assign awsize = 3'd2;
    assign arsize = 3'd2;
    assign awburst = BURST_INCR;
    assign arburst = BURST_INCR;

    // Data counts across the whole command, not per burst
    assign wvalid = state == S_WDATA;
    assign wdata = pattern + `AXI_DATA_WIDTH'(beat_idx);
    assign wlast = burst_left == LEN_BITS'(1);
    assign bready = state == S_WRESP;
    assign rready = state == S_RDATA;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            is_write <= 1'b0;
            addr <= '0;
            remaining <= '0;
            beat_idx <= '0;
            burst_left <= '0;
            pattern <= '0;
            err_acc <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
            rd_valid <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            rd_valid <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (cmd_start)
                    begin
                        is_write <= cmd_write;
                        addr <= cmd_addr;
                        remaining <= cmd_len;
                        beat_idx <= '0;
                        pattern <= cmd_pattern;
                        err_acc <= 1'b0;
                        state <= S_ADDR;
                    end
                end

                S_ADDR:
                begin
                    if ((awvalid && awready) || (arvalid && arready))
                    begin
                        burst_left <= burst_words;
                        state <= is_write ? S_WDATA : S_RDATA;
                    end
                end

                S_WDATA:
                begin
                    if (wready)
                    begin
                        addr <= addr + `AXI_ADDR_WIDTH'(4);
                        remaining <= remaining - LEN_BITS'(1);
                        beat_idx <= beat_idx + LEN_BITS'(1);
                        burst_left <= burst_left - LEN_BITS'(1);
                        if (wlast)
                            state <= S_WRESP;
                    end
                end

                S_WRESP:
                begin
                    if (bvalid)
                    begin
                        err_acc <= err_acc | (bresp != RESP_OKAY);
                        if (remaining == '0)
                        begin
                            done <= 1'b1;
                            error <= err_acc | (bresp != RESP_OKAY);
                            state <= S_IDLE;
                        end
                        else
                            state <= S_ADDR;
                    end
                end

                S_RDATA:
                begin
                    if (rvalid)
                    begin
                        rd_valid <= 1'b1;
                        err_acc <= err_acc | (rresp != RESP_OKAY);
                        addr <= addr + `AXI_ADDR_WIDTH'(4);
                        remaining <= remaining - LEN_BITS'(1);
                        if (rlast && remaining == LEN_BITS'(1))
                        begin
                            done <= 1'b1;
                            error <= err_acc | (rresp != RESP_OKAY);
                            state <= S_IDLE;
                        end
                        else if (rlast)
                            state <= S_ADDR;
                    end
                end

                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rvalid && rready)
            rd_data <= rdata;
    end

    // Write data only starts after the address has been taken by the slave
    a_w_after_aw: assert property (@(posedge clk) disable iff (reset)
        $rose(wvalid) |-> $past(awvalid && awready))
        else $error("wvalid raised without a preceding AW transfer");

endmodule

// File: logic/axi_burst_subsystem.sv
/* Burst engine, SRAM slave and bus checker joined on one AXI4 bus */
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_burst_subsystem (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          mem_busy,
    input  logic                          cmd_start,
    input  logic                          cmd_write,
    input  logic [`AXI_ADDR_WIDTH-1:0]    cmd_addr,
    input  logic [$clog2(`MAX_CMD_LEN):0] cmd_len,
    input  logic [`AXI_DATA_WIDTH-1:0]    cmd_pattern,
    output logic                          busy,
    output logic                          done,
    output logic                          error,
    output logic                          rd_valid,
    output logic [`AXI_DATA_WIDTH-1:0]    rd_data,
    output logic                          protocol_error
);
    logic                       awvalid;
    logic                       awready;
    logic [`AXI_ADDR_WIDTH-1:0] awaddr;
    logic [7:0]                 awlen;
    logic [2:0]                 awsize;
    axi_pkg::axi_burst_t        awburst;
    logic                       wvalid;
    logic                       wready;
    logic [`AXI_DATA_WIDTH-1:0] wdata;
    logic                       wlast;
    logic                       bvalid;
    logic                       bready;
    axi_pkg::axi_resp_t         bresp;
    logic                       arvalid;
    logic                       arready;
    logic [`AXI_ADDR_WIDTH-1:0] araddr;
    logic [7:0]                 arlen;
    logic [2:0]                 arsize;
    axi_pkg::axi_burst_t        arburst;
    logic                       rvalid;
    logic                       rready;
    logic [`AXI_DATA_WIDTH-1:0] rdata;
    axi_pkg::axi_resp_t         rresp;
    logic                       rlast;

    // Engine drives the bus as master and the checker only listens
    axi_burst_engine u_axi_burst_engine (.*);

    axi_sram_slave u_axi_sram_slave (.*);

    axi_protocol_checker u_axi_protocol_checker (.*);

endmodule

// File: logic/axi_pkg.sv
/* AXI burst type and response encodings shared by
   the master, the slave and the bus checker */

package axi_pkg;

    typedef enum logic [1:0]
    {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } axi_burst_t;

    typedef enum logic [1:0]
    {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_t;

endpackage

// File: logic/axi_protocol_checker.sv
/* AXI4 bus monitor for one outstanding transaction, with
   sticky error flag and concurrent assertions per rule */
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_protocol_checker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       awvalid,
    input  logic                       awready,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic [7:0]                 awlen,
    input  logic [2:0]                 awsize,
    input  axi_pkg::axi_burst_t        awburst,
    input  logic                       wvalid,
    input  logic                       wready,
    input  logic [`AXI_DATA_WIDTH-1:0] wdata,
    input  logic                       wlast,
    input  logic                       bvalid,
    input  logic                       bready,
    input  axi_pkg::axi_resp_t         bresp,
    input  logic                       arvalid,
    input  logic                       arready,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic [7:0]                 arlen,
    input  logic [2:0]                 arsize,
    input  axi_pkg::axi_burst_t        arburst,
    input  logic                       rvalid,
    input  logic                       rready,
    input  axi_pkg::axi_resp_t         rresp,
    input  logic                       rlast,
    output logic                       protocol_error
);
    import axi_pkg::*;

    localparam int PAGE_BITS = $clog2(`PAGE_BYTES);

    typedef enum logic [1:0] {IDLE, ADDR_ASSERTED, ADDR_ACCEPTED, RESPONSE} burst_state_t;

    burst_state_t               wr_state;
    logic [`AXI_ADDR_WIDTH-1:0] aw_addr_q;
    logic [7:0]                 aw_len_q;
    logic [2:0]                 aw_size_q;
    axi_burst_t                 aw_burst_q;
    logic [7:0]                 wr_count;
    burst_state_t               rd_state;
    logic [`AXI_ADDR_WIDTH-1:0] ar_addr_q;
    logic [7:0]                 ar_len_q;
    logic [2:0]                 ar_size_q;
    axi_burst_t                 ar_burst_q;
    logic [7:0]                 rd_count;
    logic                       addr_unstable;
    logic                       write_order;
    logic                       read_order;
    logic                       mid_burst;
    logic                       page_cross;
    logic                       bad_payload;

    function automatic logic crosses_page(input logic [`AXI_ADDR_WIDTH-1:0] addr,
                                          input logic [7:0] len);
        logic [`AXI_ADDR_WIDTH-1:0] last_addr;
        last_addr = addr + (`AXI_ADDR_WIDTH'(len) << 2);
        return addr[`AXI_ADDR_WIDTH-1:PAGE_BITS] != last_addr[`AXI_ADDR_WIDTH-1:PAGE_BITS];
    endfunction

    // Address fields must hold from valid until ready
    assign addr_unstable =
        (wr_state == ADDR_ASSERTED && (!awvalid || awaddr != aw_addr_q || awlen != aw_len_q
            || awsize != aw_size_q || awburst != aw_burst_q))
        || (rd_state == ADDR_ASSERTED && (!arvalid || araddr != ar_addr_q || arlen != ar_len_q
            || arsize != ar_size_q || arburst != ar_burst_q));

    // W only after AW, wlast on the final beat, B only after the last beat
    assign write_order = (wvalid && wr_state != ADDR_ACCEPTED)
        || (wr_state == ADDR_ACCEPTED && wvalid && wready && wlast != (wr_count == aw_len_q))
        || (bvalid && wr_state != RESPONSE);

    assign read_order = (rvalid && rd_state != ADDR_ACCEPTED)
        || (rd_state == ADDR_ACCEPTED && rvalid && rready && rlast != (rd_count == ar_len_q));

    assign mid_burst = (awvalid && (wr_state == ADDR_ACCEPTED || wr_state == RESPONSE))
        || (arvalid && rd_state == ADDR_ACCEPTED);

    assign page_cross = (awvalid && crosses_page(awaddr, awlen))
        || (arvalid && crosses_page(araddr, arlen));

    // No exclusive accesses are made, so EXOKAY is never legal
    assign bad_payload = (bvalid && bresp == RESP_EXOKAY) || (rvalid && rresp == RESP_EXOKAY)
        || (wvalid && $isunknown(wdata));

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            protocol_error <= 1'b0;
        else if (addr_unstable || write_order || read_order || mid_burst || page_cross
                 || bad_payload)
            protocol_error <= 1'b1;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            wr_state <= IDLE;
        else
        begin
            case (wr_state)
                IDLE:
                begin
                    if (awvalid)
                    begin
                        aw_addr_q <= awaddr;
                        aw_len_q <= awlen;
                        aw_size_q <= awsize;
                        aw_burst_q <= awburst;
                        wr_count <= 8'd0;
                        wr_state <= awready ? ADDR_ACCEPTED : ADDR_ASSERTED;
                    end
                end

                ADDR_ASSERTED:
                    if (awvalid && awready)
                        wr_state <= ADDR_ACCEPTED;

                ADDR_ACCEPTED:
                begin
                    if (wvalid && wready)
                    begin
                        wr_count <= wr_count + 8'd1;
                        if (wr_count == aw_len_q)
                            wr_state <= RESPONSE;
                    end
                end

                RESPONSE:
                    if (bvalid && bready)
                        wr_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            rd_state <= IDLE;
        else
        begin
            case (rd_state)
                IDLE:
                begin
                    if (arvalid)
                    begin
                        ar_addr_q <= araddr;
                        ar_len_q <= arlen;
                        ar_size_q <= arsize;
                        ar_burst_q <= arburst;
                        rd_count <= 8'd0;
                        rd_state <= arready ? ADDR_ACCEPTED : ADDR_ASSERTED;
                    end
                end

                ADDR_ASSERTED:
                    if (arvalid && arready)
                        rd_state <= ADDR_ACCEPTED;

                ADDR_ACCEPTED:
                begin
                    if (rvalid && rready)
                    begin
                        rd_count <= rd_count + 8'd1;
                        if (rd_count == ar_len_q)
                            rd_state <= IDLE;
                    end
                end

                default:
                    rd_state <= IDLE;
            endcase
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable({awaddr, awlen, awsize, awburst}))
        else $error("AW channel changed before acceptance");
    a_ar_stable: assert property (@(posedge clk) disable iff (reset)
        arvalid && !arready |=> arvalid && $stable({araddr, arlen, arsize, arburst}))
        else $error("AR channel changed before acceptance");
    a_write_order: assert property (@(posedge clk) disable iff (reset) !write_order)
        else $error("W or B beat out of order, or wlast misplaced");
    a_read_order: assert property (@(posedge clk) disable iff (reset) !read_order)
        else $error("R beat outside a burst, or rlast misplaced");
    a_no_mid_burst: assert property (@(posedge clk) disable iff (reset) !mid_burst)
        else $error("New address issued during a burst");
    a_page: assert property (@(posedge clk) disable iff (reset) !page_cross)
        else $error("Burst crosses a 4 KB page");
    a_payload: assert property (@(posedge clk) disable iff (reset) !bad_payload)
        else $error("Unknown write data or EXOKAY response");

endmodule

// File: logic/axi_sram_slave.sv
/* AXI slave on a word array, with external stall input
   and SLVERR for beats outside the array */
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_sram_slave (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       mem_busy,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [`AXI_ADDR_WIDTH-1:0] awaddr,
    input  logic [7:0]                 awlen,
    input  axi_pkg::axi_burst_t        awburst,
    input  logic                       wvalid,
    output logic                       wready,
    input  logic [`AXI_DATA_WIDTH-1:0] wdata,
    input  logic                       wlast,
    output logic                       bvalid,
    input  logic                       bready,
    output axi_pkg::axi_resp_t         bresp,
    input  logic                       arvalid,
    output logic                       arready,
    input  logic [`AXI_ADDR_WIDTH-1:0] araddr,
    input  logic [7:0]                 arlen,
    input  axi_pkg::axi_burst_t        arburst,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [`AXI_DATA_WIDTH-1:0] rdata,
    output axi_pkg::axi_resp_t         rresp,
    output logic                       rlast
);
    import axi_pkg::*;

    localparam int MEM_BITS = $clog2(`SRAM_WORDS);
    localparam int IDX_BITS = `AXI_ADDR_WIDTH - 2;

    typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_t;
    typedef enum logic {R_IDLE, R_DATA} rd_state_t;

    logic [`AXI_DATA_WIDTH-1:0] mem [0:`SRAM_WORDS-1];

    wr_state_t           wr_state;
    logic [IDX_BITS-1:0] wr_idx;
    logic [7:0]          wr_count;
    logic                wr_err;
    logic                wr_in_range;
    rd_state_t           rd_state;
    logic [IDX_BITS-1:0] rd_idx;
    logic [7:0]          rd_count;
    logic                rd_in_range;

    assign wr_in_range = wr_idx < IDX_BITS'(`SRAM_WORDS);
    assign rd_in_range = rd_idx < IDX_BITS'(`SRAM_WORDS);

    // A busy memory hides every handshake signal
    assign awready = wr_state == W_IDLE && !mem_busy;
    assign wready = wr_state == W_DATA && !mem_busy;
    assign bvalid = wr_state == W_RESP && !mem_busy;
    assign bresp = wr_err ? RESP_SLVERR : RESP_OKAY;
    assign arready = rd_state == R_IDLE && !mem_busy;
    assign rvalid = rd_state == R_DATA && !mem_busy;
    assign rdata = rd_in_range ? mem[rd_idx[MEM_BITS-1:0]] : '0;
    assign rresp = rd_in_range ? RESP_OKAY : RESP_SLVERR;
    assign rlast = rd_count == 8'd0;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wr_state <= W_IDLE;
            wr_idx <= '0;
            wr_count <= '0;
            wr_err <= 1'b0;
        end
        else
        begin
            case (wr_state)
                W_IDLE:
                begin
                    if (awvalid && awready)
                    begin
                        wr_idx <= awaddr[`AXI_ADDR_WIDTH-1:2];
                        wr_count <= awlen;
                        wr_err <= 1'b0;
                        wr_state <= W_DATA;
                    end
                end

                W_DATA:
                begin
                    if (wvalid && wready)
                    begin
                        // Out-of-range beats are dropped and poison the response
                        if (!wr_in_range)
                            wr_err <= 1'b1;
                        wr_idx <= wr_idx + IDX_BITS'(1);
                        wr_count <= wr_count - 8'd1;
                        if (wr_count == 8'd0)
                            wr_state <= W_RESP;
                    end
                end

                W_RESP:
                begin
                    if (bvalid && bready)
                        wr_state <= W_IDLE;
                end

                default:
                    wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wvalid && wready && wr_in_range)
            mem[wr_idx[MEM_BITS-1:0]] <= wdata;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            rd_state <= R_IDLE;
            rd_idx <= '0;
            rd_count <= '0;
        end
        else if (rd_state == R_IDLE)
        begin
            if (arvalid && arready)
            begin
                rd_idx <= araddr[`AXI_ADDR_WIDTH-1:2];
                rd_count <= arlen;
                rd_state <= R_DATA;
            end
        end
        else if (rvalid && rready)
        begin
            rd_idx <= rd_idx + IDX_BITS'(1);
            rd_count <= rd_count - 8'd1;
            if (rlast)
                rd_state <= R_IDLE;
        end
    end

    a_incr_only: assert property (@(posedge clk) disable iff (reset)
        (awvalid |-> awburst == BURST_INCR) and (arvalid |-> arburst == BURST_INCR))
        else $error("Burst type other than INCR");

    // The master's wlast must agree with the length taken from AW
    a_wlast_len: assert property (@(posedge clk) disable iff (reset)
        wvalid && wready |-> wlast == (wr_count == 8'd0))
        else $error("wlast does not match awlen");

endmodule

// File: test/axi_burst_subsystem_tb.sv
/* Testbench for the AXI burst subsystem, with a reference memory
   model, random command stimulus and checking assertions */
`timescale 1ns/1ps
`include "axi_defs.svh"

module axi_burst_subsystem_tb;

    localparam int NUM_RANDOM = 12;
    localparam int NUM_MIXED = 10;
    localparam int NUM_CMDS = 4 + 2 * NUM_RANDOM + 2 + NUM_MIXED + 2 + 2;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * (`MAX_CMD_LEN * 8 + 40);
    localparam int LEN_BITS = $clog2(`MAX_CMD_LEN) + 1;
    localparam int MEM_BITS = $clog2(`SRAM_WORDS);

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       mem_busy = 1'b0;
    logic                       cmd_start;
    logic                       cmd_write;
    logic [`AXI_ADDR_WIDTH-1:0] cmd_addr;
    logic [LEN_BITS-1:0]        cmd_len;
    logic [`AXI_DATA_WIDTH-1:0] cmd_pattern;
    logic                       busy;
    logic                       done;
    logic                       error;
    logic                       rd_valid;
    logic [`AXI_DATA_WIDTH-1:0] rd_data;
    logic                       protocol_error;

    integer seed = 76;
    int     cycle_count = 0;
    logic   stall_en = 1'b0;
    logic   waiting = 1'b0;
    logic   exp_error = 1'b0;
    int     rnd_word [NUM_RANDOM + NUM_MIXED];
    int     rnd_len [NUM_RANDOM + NUM_MIXED];
    int     rnd_pat [NUM_RANDOM + NUM_MIXED];
    int     rnd_wr [NUM_RANDOM + NUM_MIXED];

    // Reference memory and the read words still expected
    logic [`AXI_DATA_WIDTH-1:0] model_mem [0:`SRAM_WORDS-1];
    logic [`AXI_DATA_WIDTH-1:0] exp_q [$];

    axi_burst_subsystem u_axi_burst_subsystem (.*);

    always #2 clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        $display("Checks failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic fail_run(input string msg);
        $display("ERROR: %s", msg);
        $display("Checks failed");
        $fatal(1, "Stopped at first error");
    endtask

    // Update the model and queue expected read data before the command runs
    task automatic predict_command(input logic write, input int word, input int len,
                                   input logic [`AXI_DATA_WIDTH-1:0] pattern);
        exp_error = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            if (word + i >= `SRAM_WORDS)
                exp_error = 1'b1;
            else if (write)
                model_mem[MEM_BITS'(word + i)] = pattern + 32'(i);
            if (!write)
                exp_q.push_back((word + i < `SRAM_WORDS) ? model_mem[MEM_BITS'(word + i)] : '0);
        end
    endtask

    // Stray start goes in while the command is running, with other data
    task automatic run_command(input logic write, input int word, input int len,
                               input logic [`AXI_DATA_WIDTH-1:0] pattern, input logic stray);
        predict_command(write, word, len, pattern);
        @(posedge clk);
        cmd_start <= 1'b1;
        cmd_write <= write;
        cmd_addr <= 32'(word * 4);
        cmd_len <= LEN_BITS'(len);
        cmd_pattern <= pattern;
        waiting = 1'b1;
        @(posedge clk);
        cmd_start <= 1'b0;
        if (stray)
        begin
            @(posedge clk);
            assert (busy) else fail_run("DUT was not busy when the stray start was driven");
            cmd_start <= 1'b1;
            cmd_write <= 1'b1;
            cmd_pattern <= ~pattern;
            @(posedge clk);
            cmd_start <= 1'b0;
        end
        while (!done)
            @(posedge clk);
        waiting = 1'b0;
        @(posedge clk);
    endtask

    always @(posedge clk)
    begin
        if (stall_en)
            mem_busy <= ($random(seed) & 3) == 0;
        else
            mem_busy <= 1'b0;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run("timeout, the command sequence did not finish in time");
    end

    // Read data in address order, beat count and error flag at done
    always @(posedge clk)
    begin
        if (reset)
            assert (!busy && !done && !error && !rd_valid && !protocol_error)
            else report_mismatch("status output high during reset");
        if (rd_valid)
        begin
            assert (exp_q.size() > 0) else report_mismatch("more rd_valid pulses than cmd_len");
            assert (rd_data === exp_q[0])
            else report_mismatch($sformatf("rd_data %h, expected %h", rd_data, exp_q[0]));
            void'(exp_q.pop_front());
        end
        if (done)
        begin
            assert (error == exp_error)
            else report_mismatch($sformatf("error %b at done, expected %b", error, exp_error));
            assert (exp_q.size() == 0) else report_mismatch("fewer rd_valid pulses than cmd_len");
        end
    end

    a_no_protocol_error: assert property (@(posedge clk) disable iff (reset) !protocol_error)
        else fail_run("protocol checker flagged a bus violation");
    a_accept: assert property (@(posedge clk) disable iff (reset) cmd_start && !busy |=> busy)
        else fail_run("start while idle was not accepted");
    a_busy_held: assert property (@(posedge clk) disable iff (reset) busy |=> busy || done)
        else fail_run("busy dropped before done");
    a_done_expected: assert property (@(posedge clk) disable iff (reset) done |-> waiting)
        else fail_run("done pulse with no command outstanding");

    initial
    begin
        reset = 1'b1;
        cmd_start = 1'b0;
        cmd_write = 1'b0;
        cmd_addr = '0;
        cmd_len = '0;
        cmd_pattern = '0;
        for (int i = 0; i < NUM_RANDOM + NUM_MIXED; i++)
        begin
            rnd_word[i] = {$random(seed)} % (`SRAM_WORDS - `MAX_CMD_LEN);
            rnd_len[i] = 1 + {$random(seed)} % `MAX_CMD_LEN;
            rnd_pat[i] = $random(seed);
            rnd_wr[i] = $random(seed) & 1;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!busy && !done && !error && !rd_valid && !protocol_error)
        else report_mismatch("status output high just after reset");

        run_command(1'b1, 256, 1, 32'hA5A5_0000, 1'b0);
        run_command(1'b0, 256, 1, '0, 1'b0);
        run_command(1'b1, 512, `MAX_CMD_LEN, 32'h1234_5600, 1'b0);
        run_command(1'b0, 512, `MAX_CMD_LEN, '0, 1'b0);
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            run_command(1'b1, rnd_word[i], rnd_len[i], 32'(rnd_pat[i]), 1'b0);
            run_command(1'b0, rnd_word[i], rnd_len[i], '0, 1'b0);
        end

        // Three words before the first page boundary
        run_command(1'b1, 1024 - 3, 10, 32'hC0DE_0000, 1'b0);
        run_command(1'b0, 1024 - 3, 10, '0, 1'b0);

        // Mixed commands revisit the regions written above
        stall_en <= 1'b1;
        for (int i = 0; i < NUM_MIXED; i++)
            run_command(rnd_wr[NUM_RANDOM + i] != 0, rnd_word[i], rnd_len[i],
                        32'(rnd_pat[NUM_RANDOM + i]), 1'b0);
        run_command(1'b1, 1536, 12, 32'h5500_0000, 1'b1);
        run_command(1'b0, 1536, 12, '0, 1'b0);
        stall_en <= 1'b0;

        // Last four words in range, the rest past the end of the SRAM
        run_command(1'b1, `SRAM_WORDS - 4, 10, 32'hE0E0_0000, 1'b0);
        run_command(1'b0, `SRAM_WORDS - 4, 10, '0, 1'b0);

        repeat (4) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule
